// File: verilog/apb_sub_pkg.sv
package apb_sub_pkg;

   // ----------------------------------------
   // Bus widths and slot counts
   // ----------------------------------------
   localparam int addr_w      = 32;
   localparam int data_w      = 32;
   localparam int num_regions = 5;
   localparam int num_mac     = 4;

   // Slot order in the region vectors
   localparam int region_alut = 0;
   localparam int region_mac0 = 1;

   // ----------------------------------------
   // Address map
   // ----------------------------------------
   // Each region spans 64 KiB
   localparam logic [addr_w-1:0] region_mask = 32'hFFFF_0000;

   // ALUT first, then MAC 0 to MAC 3
   localparam logic [addr_w-1:0] region_base [num_regions] = '{
      32'h00A0_0000,
      32'h00A1_0000,
      32'h00A2_0000,
      32'h00A3_0000,
      32'h00A4_0000
   };

   // One bit per region, at most one set
   typedef logic [num_regions-1:0] region_sel_t;

   // ----------------------------------------
   // AHB-lite encodings
   // ----------------------------------------
   typedef enum logic [1:0] {
      htrans_idle   = 2'b00,
      htrans_busy   = 2'b01,
      htrans_nonseq = 2'b10,
      htrans_seq    = 2'b11
   } htrans_t;

   typedef enum logic [1:0] {
      hresp_okay  = 2'b00,
      hresp_error = 2'b01
   } hresp_t;

endpackage

// File: verilog/alut_pkg.sv
package alut_pkg;

   // ----------------------------------------
   // Table geometry
   // ----------------------------------------
   localparam int alut_entries = 4;
   localparam int idx_w        = $clog2(alut_entries);
   localparam int key_w        = 48;
   localparam int port_w       = 2;

   // ----------------------------------------
   // Register offsets, paddr bits 6:0
   // ----------------------------------------
   localparam int off_w = 7;
   localparam logic [off_w-1:0] off_key_lo = 7'h00;
   localparam logic [off_w-1:0] off_key_hi = 7'h04;
   localparam logic [off_w-1:0] off_cmd    = 7'h08;
   localparam logic [off_w-1:0] off_result = 7'h0C;

   // Command word fields
   localparam int cmd_op_bit   = 0;
   localparam int cmd_idx_lsb  = 4;
   localparam int cmd_port_lsb = 8;
   localparam logic op_learn   = 1'b0;
   localparam logic op_lookup  = 1'b1;

   // Result word fields
   localparam int res_hit_bit  = 31;
   localparam int res_idx_lsb  = 4;
   localparam int res_port_lsb = 0;

   typedef struct packed {
      logic              valid;
      logic [key_w-1:0]  key;
      logic [port_w-1:0] port;
   } alut_entry_t;

endpackage

// File: verilog/apb_bus_if.sv
interface apb_bus_if;
   import apb_sub_pkg::*;

   // Request side, driven by the bridge
   logic [addr_w-1:0] paddr;
   logic              pwrite;
   logic              penable;
   logic [data_w-1:0] pwdata;
   // Single bit, true for the whole transfer
   logic              psel;

   // Return side, muxed by the router
   logic [data_w-1:0] prdata;
   logic              pready;

   modport master (
      output paddr, pwrite, penable, pwdata, psel,
      input  prdata, pready
   );

   // Router only needs the address and the transfer flag
   modport router (
      input  paddr, psel,
      output prdata, pready
   );

   modport slave (
      input  paddr, pwrite, penable, pwdata, psel,
      output prdata, pready
   );

endinterface

// File: verilog/ahb_apb_bridge.sv
module ahb_apb_bridge (
   input  logic                           hclk,
   input  logic                           arst_n,
   input  logic                           hsel,
   input  logic                           hready_in,
   input  logic                           hwrite,
   input  apb_sub_pkg::htrans_t           htrans,
   input  logic [apb_sub_pkg::addr_w-1:0] haddr,
   input  logic [apb_sub_pkg::data_w-1:0] hwdata,
   output logic [apb_sub_pkg::data_w-1:0] hrdata,
   output logic                           hready,
   output apb_sub_pkg::hresp_t            hresp,
   input  logic                           decode_err,
   apb_bus_if.master                      apb
);
   import apb_sub_pkg::*;

   // Setup state doubles as the first ERROR cycle when decode fails
   typedef enum logic [1:0] {
      st_idle,
      st_setup,
      st_access,
      st_err
   } state_t;

   state_t            state;
   state_t            state_nxt;
   logic              accept;
   logic [addr_w-1:0] addr_q;
   logic              write_q;
   logic [data_w-1:0] wdata_q;
   logic [data_w-1:0] rdata_q;

   // ----------------------------------------
   // AHB address phase
   // ----------------------------------------
   // Only idle and the second ERROR cycle show hready high
   assign hready = (state == st_idle) || (state == st_err);

   assign accept = hsel && hready_in && hready &&
                   (htrans inside {htrans_nonseq, htrans_seq});

   // Address and direction held for the whole APB transfer
   always_ff @(posedge hclk) begin
      if (accept) begin
         addr_q  <= haddr;
         write_q <= hwrite;
      end
   end

   // Write data arrives one cycle after the address
   always_ff @(posedge hclk) begin
      if (state == st_setup) begin
         wdata_q <= hwdata;
      end
   end

   // Read data kept stable while hready is high
   always_ff @(posedge hclk) begin
      if (state == st_access && apb.pready) begin
         rdata_q <= apb.prdata;
      end
   end

   // ----------------------------------------
   // Control FSM
   // ----------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         st_idle, st_err: begin
            state_nxt = accept ? st_setup : st_idle;
         end
         st_setup: begin
            // No APB cycle for an unmapped address
            state_nxt = decode_err ? st_err : st_access;
         end
         st_access: begin
            if (apb.pready) begin
               state_nxt = st_idle;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // ----------------------------------------
   // APB request and AHB response
   // ----------------------------------------
   assign apb.paddr   = addr_q;
   assign apb.pwrite  = write_q;
   assign apb.psel    = (state == st_setup && !decode_err) || (state == st_access);
   assign apb.penable = (state == st_access);
   // Setup cycle takes hwdata straight from the bus
   assign apb.pwdata  = (state == st_setup) ? hwdata : wdata_q;

   assign hrdata = rdata_q;

   // Both cycles of the error response
   assign hresp = ((state == st_setup && decode_err) || state == st_err) ?
                  hresp_error : hresp_okay;

endmodule

// File: verilog/apb_slave_router.sv
module apb_slave_router (
   apb_bus_if.router                                                   bus,
   output apb_sub_pkg::region_sel_t                                    psel_region,
   input  logic [apb_sub_pkg::num_regions-1:0][apb_sub_pkg::data_w-1:0] prdata_region,
   input  logic [apb_sub_pkg::num_regions-1:0]                         pready_region,
   output logic                                                        decode_err
);
   import apb_sub_pkg::*;

   region_sel_t hit;

   // ----------------------------------------
   // Region decode
   // ----------------------------------------
   // Regions never overlap, so hit is one-hot or zero
   always_comb begin
      hit = '0;
      for (int k = 0; k < num_regions; k++) begin
         hit[k] = (bus.paddr & region_mask) == region_base[k];
      end
   end

   // Selects only while the bridge runs a transfer
   assign psel_region = hit & {num_regions{bus.psel}};

   // Independent of psel, the bridge reads it in the setup cycle
   assign decode_err = ~|hit;

   // ----------------------------------------
   // Return path
   // ----------------------------------------
   always_comb begin
      bus.prdata = '0;
      bus.pready = 1'b0;
      for (int k = 0; k < num_regions; k++) begin
         if (hit[k]) begin
            bus.prdata = prdata_region[k];
            bus.pready = pready_region[k];
         end
      end
   end

endmodule

// File: verilog/alut_regs.sv
module alut_regs (
   input  logic                           hclk,
   input  logic                           arst_n,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [alut_pkg::off_w-1:0]     paddr,
   input  logic [apb_sub_pkg::data_w-1:0] pwdata,
   output logic [apb_sub_pkg::data_w-1:0] prdata
);
   import apb_sub_pkg::*;
   import alut_pkg::*;

   logic [31:0]             key_lo;
   logic [key_w-33:0]       key_hi;
   logic [key_w-1:0]        key;
   alut_entry_t             entries [alut_entries];
   logic [data_w-1:0]       result_q;
   logic [data_w-1:0]       result_d;
   logic [alut_entries-1:0] match;
   logic                    wr;
   logic                    wr_cmd;
   logic                    cmd_op;
   logic [idx_w-1:0]        cmd_idx;
   logic [port_w-1:0]       cmd_port;
   logic                    found;
   logic [idx_w-1:0]        found_idx;
   logic [port_w-1:0]       found_port;

   // Writes land at the end of the access cycle
   assign wr     = psel && penable && pwrite;
   assign wr_cmd = wr && (paddr == off_cmd);

   assign cmd_op   = pwdata[cmd_op_bit];
   assign cmd_idx  = pwdata[cmd_idx_lsb +: idx_w];
   assign cmd_port = pwdata[cmd_port_lsb +: port_w];

   // ----------------------------------------
   // Key registers
   // ----------------------------------------
   always_ff @(posedge hclk) begin
      if (wr && paddr == off_key_lo) begin
         key_lo <= pwdata;
      end
      if (wr && paddr == off_key_hi) begin
         key_hi <= pwdata[key_w-33:0];
      end
   end

   assign key = {key_hi, key_lo};

   // ----------------------------------------
   // Parallel compare, lowest index wins
   // ----------------------------------------
   always_comb begin
      for (int k = 0; k < alut_entries; k++) begin
         match[k] = entries[k].valid && (entries[k].key == key);
      end
   end

   always_comb begin
      found      = 1'b0;
      found_idx  = '0;
      found_port = '0;
      // Walk downwards so the last hit kept is the lowest
      for (int k = alut_entries - 1; k >= 0; k--) begin
         if (match[k]) begin
            found      = 1'b1;
            found_idx  = idx_w'(k);
            found_port = entries[k].port;
         end
      end
   end

   // Miss packs to all zeros
   always_comb begin
      result_d = '0;
      result_d[res_hit_bit] = found;
      result_d[res_idx_lsb +: idx_w] = found_idx;
      result_d[res_port_lsb +: port_w] = found_port;
   end

   // ----------------------------------------
   // Learn and lookup
   // ----------------------------------------
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         for (int k = 0; k < alut_entries; k++) begin
            entries[k].valid <= 1'b0;
         end
         result_q <= '0;
      end else if (wr_cmd) begin
         if (cmd_op == op_learn) begin
            entries[cmd_idx].valid <= 1'b1;
            entries[cmd_idx].key   <= key;
            entries[cmd_idx].port  <= cmd_port;
         end else begin
            result_q <= result_d;
         end
      end
   end

   // Readback, command register reads as zero
   always_comb begin
      case (paddr)
         off_key_lo: prdata = key_lo;
         off_key_hi: prdata = data_w'(key_hi);
         off_result: prdata = result_q;
         default:    prdata = '0;
      endcase
   end

endmodule

// File: verilog/apb_subsystem.sv
module apb_subsystem (
   input  logic                                                    hclk,
   input  logic                                                    arst_n,
   // AHB-lite slave port
   input  logic                                                    hsel,
   input  logic [apb_sub_pkg::addr_w-1:0]                          haddr,
   input  apb_sub_pkg::htrans_t                                    htrans,
   input  logic                                                    hwrite,
   input  logic [apb_sub_pkg::data_w-1:0]                          hwdata,
   input  logic                                                    hready_in,
   output logic [apb_sub_pkg::data_w-1:0]                          hrdata,
   output logic                                                    hready,
   output apb_sub_pkg::hresp_t                                     hresp,
   // Shared APB request lines
   output logic [apb_sub_pkg::addr_w-1:0]                          paddr,
   output logic                                                    pwrite,
   output logic                                                    penable,
   output logic [apb_sub_pkg::data_w-1:0]                          pwdata,
   // MAC register ports
   output logic [apb_sub_pkg::num_mac-1:0]                         psel_mac,
   input  logic [apb_sub_pkg::num_mac-1:0][apb_sub_pkg::data_w-1:0] prdata_mac,
   input  logic [apb_sub_pkg::num_mac-1:0]                         pready_mac
);
   import apb_sub_pkg::*;
   import alut_pkg::*;

   region_sel_t                            psel_region;
   logic [num_regions-1:0][data_w-1:0]     prdata_region;
   logic [num_regions-1:0]                 pready_region;
   logic [data_w-1:0]                      prdata_alut;
   logic                                   decode_err;

   apb_bus_if apb_bus ();

   // ----------------------------------------
   // Slot wiring, ALUT in slot 0
   // ----------------------------------------
   assign prdata_region[region_alut]          = prdata_alut;
   assign prdata_region[region_mac0 +: num_mac] = prdata_mac;
   // ALUT never stalls
   assign pready_region[region_alut]          = 1'b1;
   assign pready_region[region_mac0 +: num_mac] = pready_mac;

   assign psel_mac = psel_region[region_mac0 +: num_mac];

   assign paddr   = apb_bus.paddr;
   assign pwrite  = apb_bus.pwrite;
   assign penable = apb_bus.penable;
   assign pwdata  = apb_bus.pwdata;

   ahb_apb_bridge ahb_apb_bridge_inst (
      .hclk       (hclk),
      .arst_n     (arst_n),
      .hsel       (hsel),
      .hready_in  (hready_in),
      .hwrite     (hwrite),
      .htrans     (htrans),
      .haddr      (haddr),
      .hwdata     (hwdata),
      .hrdata     (hrdata),
      .hready     (hready),
      .hresp      (hresp),
      .decode_err (decode_err),
      .apb        (apb_bus)
   );

   apb_slave_router apb_slave_router_inst (
      .bus           (apb_bus),
      .psel_region   (psel_region),
      .prdata_region (prdata_region),
      .pready_region (pready_region),
      .decode_err    (decode_err)
   );

   // Only the low offset bits reach the register block
   alut_regs alut_regs_inst (
      .hclk    (hclk),
      .arst_n  (arst_n),
      .psel    (psel_region[region_alut]),
      .penable (apb_bus.penable),
      .pwrite  (apb_bus.pwrite),
      .paddr   (apb_bus.paddr[off_w-1:0]),
      .pwdata  (apb_bus.pwdata),
      .prdata  (prdata_alut)
   );

endmodule

// File: test/tb_clock_gen.sv
module tb_clock_gen #(
   parameter int period = 40
) (
   output logic clk
);

   // Free running, starts low
   initial begin
      clk = 1'b0;
   end

   always begin
      #(period / 2) clk = ~clk;
   end

endmodule

// File: test/apb_subsystem_props.sv
module apb_subsystem_props (
   input logic                                     hclk,
   input logic                                     arst_n,
   input apb_sub_pkg::region_sel_t                 psel_region,
   input logic                                     penable,
   input logic [apb_sub_pkg::addr_w-1:0]           paddr,
   input logic                                     pwrite,
   input logic [apb_sub_pkg::num_mac-1:0]          psel_mac,
   input logic                                     hready,
   input apb_sub_pkg::hresp_t                      hresp
);
   import apb_sub_pkg::*;

   logic psel_any;

   // Any region selected means an APB transfer is running
   assign psel_any = |psel_region;

   // ----------------------------------------
   // APB rules
   // ----------------------------------------
   // Access cycle only after a setup cycle
   penable_after_setup: assert property (@(posedge hclk) disable iff (!arst_n)
      $rose(penable) |-> $past(psel_any && !penable))
      else $error("penable rose without a setup cycle");

   // Request held for the whole transfer
   request_stable: assert property (@(posedge hclk) disable iff (!arst_n)
      (psel_any && $past(psel_any)) |-> ($stable(paddr) && $stable(pwrite)))
      else $error("paddr or pwrite changed while psel was high");

   // At most one MAC selected, and only while AHB waits
   mac_select_onehot: assert property (@(posedge hclk) disable iff (!arst_n)
      $onehot0(psel_mac) && (psel_mac == '0 || !hready))
      else $error("MAC select not one-hot or high outside a transfer");

   // ----------------------------------------
   // AHB error response, two cycles
   // ----------------------------------------
   error_second_cycle: assert property (@(posedge hclk) disable iff (!arst_n)
      (hresp == hresp_error && !hready) |=> (hresp == hresp_error && hready))
      else $error("ERROR response not followed by its second cycle");

   error_first_cycle: assert property (@(posedge hclk) disable iff (!arst_n)
      (hresp == hresp_error && hready) |-> $past(hresp == hresp_error && !hready))
      else $error("ERROR response with hready high lacked its first cycle");

endmodule

bind apb_subsystem apb_subsystem_props apb_subsystem_props_inst (
   .hclk        (hclk),
   .arst_n      (arst_n),
   .psel_region (psel_region),
   .penable     (penable),
   .paddr       (paddr),
   .pwrite      (pwrite),
   .psel_mac    (psel_mac),
   .hready      (hready),
   .hresp       (hresp)
);

// File: test/apb_subsystem_tb.sv
module apb_subsystem_tb;
   import apb_sub_pkg::*;

   localparam int clk_period        = 40;
   localparam int reset_cycles      = 16;
   localparam int cycles_per_vector = 20;

   logic                           hclk;
   logic                           arst_n;
   logic                           hsel;
   logic                           hwrite;
   logic                           hready_in;
   htrans_t                        htrans;
   logic [addr_w-1:0]              haddr;
   logic [data_w-1:0]              hwdata;
   logic [data_w-1:0]              hrdata;
   logic                           hready;
   hresp_t                         hresp;
   logic [addr_w-1:0]              paddr;
   logic                           pwrite;
   logic                           penable;
   logic [data_w-1:0]              pwdata;
   logic [num_mac-1:0]             psel_mac;
   logic [num_mac-1:0][data_w-1:0] prdata_mac;
   logic [num_mac-1:0]             pready_mac = '0;

   // Vector columns
   logic        vec_write [$];
   logic [31:0] vec_addr [$];
   logic [31:0] vec_wdata [$];
   logic [31:0] vec_rdata [$];
   logic [1:0]  vec_resp [$];

   // MAC model state
   logic [1:0]  wait_cnt [num_mac];
   logic [31:0] last_wr_addr [num_mac];
   logic [31:0] last_wr_data [num_mac];
   logic [31:0] rng_state = 32'he0ec_66c6;

   int   errors = 0;
   int   test_errors = 0;
   int   passes = 0;
   int   n_vec = 0;
   logic loaded = 1'b0;

   tb_clock_gen #(.period(clk_period)) tb_clock_gen_inst (.clk(hclk));

   apb_subsystem apb_subsystem_inst (
      .hclk       (hclk),
      .arst_n     (arst_n),
      .hsel       (hsel),
      .haddr      (haddr),
      .htrans     (htrans),
      .hwrite     (hwrite),
      .hwdata     (hwdata),
      .hready_in  (hready_in),
      .hrdata     (hrdata),
      .hready     (hready),
      .hresp      (hresp),
      .paddr      (paddr),
      .pwrite     (pwrite),
      .penable    (penable),
      .pwdata     (pwdata),
      .psel_mac   (psel_mac),
      .prdata_mac (prdata_mac),
      .pready_mac (pready_mac)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // ----------------------------------------
   // MAC port models
   // ----------------------------------------
   // Port number on top, address below
   always_comb begin
      for (int k = 0; k < num_mac; k++) begin
         prdata_mac[k] = {8'(k), paddr[23:0]};
      end
   end

   // 0 to 3 wait cycles, drawn in the setup cycle
   always @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         pready_mac <= '0;
         for (int k = 0; k < num_mac; k++) begin
            wait_cnt[k] <= 2'd0;
         end
      end else begin
         for (int k = 0; k < num_mac; k++) begin
            if (psel_mac[k] && !penable) begin
               rng_state = xorshift32(rng_state);
               wait_cnt[k]   <= rng_state[1:0];
               pready_mac[k] <= (rng_state[1:0] == 2'd0);
            end else if (psel_mac[k] && penable) begin
               if (pready_mac[k]) begin
                  pready_mac[k] <= 1'b0;
                  if (pwrite) begin
                     last_wr_addr[k] <= paddr;
                     last_wr_data[k] <= pwdata;
                  end
               end else begin
                  wait_cnt[k]   <= wait_cnt[k] - 2'd1;
                  pready_mac[k] <= (wait_cnt[k] == 2'd1);
               end
            end
         end
      end
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   task automatic load_vectors();
      int          fd;
      string       line;
      logic [31:0] op;
      logic [31:0] addr;
      logic [31:0] wd;
      logic [31:0] rd;
      logic [31:0] rs;
      fd = $fopen("test/apb_subsystem_vectors.txt", "r");
      if (fd == 0) begin
         $display("Vector file could not be opened");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip comments and blank lines
            if (line.len() > 0 && line[0] != 8'h23) begin
               if ($sscanf(line, "%h %h %h %h %h", op, addr, wd, rd, rs) == 5) begin
                  vec_write.push_back(op[0]);
                  vec_addr.push_back(addr);
                  vec_wdata.push_back(wd);
                  vec_rdata.push_back(rd);
                  vec_resp.push_back(rs[1:0]);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic drive_address(input int i);
      hsel   <= 1'b1;
      htrans <= htrans_nonseq;
      haddr  <= vec_addr[i];
      hwrite <= vec_write[i];
   endtask

   task automatic drive_idle();
      hsel   <= 1'b0;
      htrans <= htrans_idle;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
         test_errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond) else begin
         $display("At %0t: %s", $time, what);
         test_errors++;
      end
   endtask

   task automatic report_test(input int num, input string what);
      $display("Test %0d %s: %s", num, what, (test_errors == 0) ? "pass" : "FAIL");
      errors += test_errors;
      if (test_errors == 0) begin
         passes++;
      end
   endtask

   // Region index from the address map, -1 when unmapped
   function automatic int region_of(input logic [31:0] addr);
      if (addr[31:24] == 8'h00 && addr[23:16] >= 8'hA0 && addr[23:16] <= 8'hA4) begin
         return int'(addr[23:16]) - 'hA0;
      end
      return -1;
   endfunction

   // ----------------------------------------
   // Watchdog
   // ----------------------------------------
   initial begin
      wait (loaded);
      #((reset_cycles + (n_vec + 2) * cycles_per_vector) * clk_period);
      $display("Watchdog expired before all tests finished");
      $display("Simulation failed");
      $finish;
   end

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      logic [3:0] sel_seen;
      logic       pen_seen;
      int         region;
      string      what;
      hsel       = 1'b0;
      hwrite     = 1'b0;
      hready_in  = 1'b1;
      htrans     = htrans_idle;
      haddr      = '0;
      hwdata     = '0;
      arst_n     = 1'b0;
      load_vectors();
      n_vec  = vec_addr.size();
      loaded = 1'b1;
      repeat (reset_cycles) @(posedge hclk);
      arst_n <= 1'b1;

      // Idle outputs after reset
      @(negedge hclk);
      test_errors = 0;
      check_value("hready", 32'(hready), 32'd1);
      check_value("hresp", 32'(hresp), 32'(hresp_okay));
      check_value("psel_mac", 32'(psel_mac), 32'd0);
      check_value("penable", 32'(penable), 32'd0);
      report_test(0, "reset");

      if (n_vec > 0) begin
         @(posedge hclk);
         drive_address(0);
         @(negedge hclk);
      end

      // Next address goes out with this data phase, so transfers run back to back
      for (int i = 0; i < n_vec; i++) begin
         @(posedge hclk);
         hwdata <= vec_wdata[i];
         if (i + 1 < n_vec) begin
            drive_address(i + 1);
         end else begin
            drive_idle();
         end
         sel_seen    = '0;
         pen_seen    = 1'b0;
         test_errors = 0;
         do begin
            @(negedge hclk);
            sel_seen = sel_seen | psel_mac;
            pen_seen = pen_seen | penable;
            // Request lines during every access cycle
            if (penable) begin
               check_value("pwrite", 32'(pwrite), 32'(vec_write[i]));
               check_value("paddr", paddr, vec_addr[i]);
            end
         end while (!hready);

         region = region_of(vec_addr[i]);
         check_value("hresp", 32'(hresp), 32'(vec_resp[i]));
         if (vec_resp[i] == 2'(hresp_error)) begin
            check_true(sel_seen == 4'd0 && !pen_seen,
                       "APB transfer started for an unmapped address");
         end else if (region >= 1) begin
            check_value("psel_mac", 32'(sel_seen), 32'(1 << (region - 1)));
            if (vec_write[i]) begin
               check_value("paddr", last_wr_addr[region-1], vec_addr[i]);
               check_value("pwdata", last_wr_data[region-1], vec_wdata[i]);
            end
         end else begin
            check_true(sel_seen == 4'd0 && pen_seen, "ALUT access gave no APB transfer");
         end
         // Read data only defined on an OKAY response
         if (!vec_write[i] && vec_resp[i] != 2'(hresp_error)) begin
            check_value("hrdata", hrdata, vec_rdata[i]);
         end
         what = $sformatf("%s %h", vec_write[i] ? "write" : "read", vec_addr[i]);
         report_test(i + 1, what);
      end

      $display("Tests run %0d, passed %0d, failed %0d", n_vec + 1, passes,
               n_vec + 1 - passes);
      if (errors == 0 && n_vec > 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: test/apb_subsystem_vectors.txt
# op (1 write, 0 read)  address  write data  expected read data  expected hresp (1 ERROR)
# MAC writes, regions 1 to 4
1 00A10010 11112222 00000000 0
1 00A20024 33334444 00000000 0
1 00A30038 55556666 00000000 0
1 00A4FFFC 77778888 00000000 0
# MAC reads
0 00A10100 00000000 00A10100 0
0 00A20200 00000000 01A20200 0
0 00A30300 00000000 02A30300 0
0 00A4FFF0 00000000 03A4FFF0 0
# ALUT key write and readback, learn index 2 port 3, lookup
1 00A00000 DEADBEEF 00000000 0
1 00A00004 0000CAFE 00000000 0
0 00A00000 00000000 DEADBEEF 0
0 00A00004 00000000 0000CAFE 0
1 00A00008 00000320 00000000 0
1 00A00008 00000001 00000000 0
0 00A0000C 00000000 80000023 0
# Unlearned key misses
1 00A00000 12345678 00000000 0
1 00A00008 00000001 00000000 0
0 00A0000C 00000000 00000000 0
# Unmapped addresses
0 00B00000 00000000 00000000 1
1 00000040 ABCDEF01 00000000 1
0 00A50000 00000000 00000000 1
# Write then read on one MAC right after an error
1 00A20008 0BADF00D 00000000 0
0 00A20008 00000000 01A20008 0

// File: flist.f
verilog/apb_sub_pkg.sv
verilog/alut_pkg.sv
verilog/apb_bus_if.sv
verilog/ahb_apb_bridge.sv
verilog/apb_slave_router.sv
verilog/alut_regs.sv
verilog/apb_subsystem.sv
test/tb_clock_gen.sv
test/apb_subsystem_props.sv
test/apb_subsystem_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= apb_subsystem_tb
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL"; exit 1; \
	fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
